// ==== all.f ====
+incdir+.
apu_pkg.sv
apu_code_ram.sv
apu_fetch.sv
apu_decode.sv
apu_alu.sv
apu_regs.sv
apu_port_out.sv
apu.sv
apu_sva.sv
tb_apu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the apu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_apu -f all.f -o tb_apu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out="$(./obj_dir/tb_apu_sim 2>&1)"
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
else
	exit 1
fi

// ==== tb_apu.sv ====
`include "apu_config.svh"

module tb_apu;

	logic                clk;
	logic                rst;
	logic                apu_halt;
	logic                code_wen;
	apu_pkg::load_addr_t code_waddr;
	apu_pkg::data_t      code_wdata;
	logic                apu_rdy;
	apu_pkg::data_t      apu_covox;
	logic                apu_covox_we;
	apu_pkg::border_t    apu_border;
	logic                apu_border_we;

	integer      seed;
	logic [31:0] rnd;
	logic [15:0] prog [$];        // words of the program under test
	logic [7:0]  covox_got [$];
	logic [7:0]  covox_exp [$];
	logic [7:0]  border_got [$];  // border kept zero-extended
	logic [7:0]  border_exp [$];

	apu u_apu (
		.clk, .rst, .apu_halt, .code_wen, .code_waddr, .code_wdata,
		.apu_rdy, .apu_covox, .apu_covox_we, .apu_border, .apu_border_we
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// strobed port values, sampled mid-cycle
	always @(negedge clk)
	begin
		if (apu_covox_we)
			covox_got.push_back(apu_covox);
		if (apu_border_we)
			border_got.push_back({2'b00, apu_border});
	end

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task wait_ready(input int limit);
		int n;
		n = 0;
		while (apu_rdy !== 1'b1)
		begin
			@(negedge clk);
			n++;
			if (n > limit)
			begin
				$display("timeout, apu_rdy still low after %0d cycles", limit);
				$display("TB FAILED");
				$fatal(1);
			end
		end
	endtask

	// instruction encoders
	function automatic logic [15:0] imm_word(input logic [2:0] fn, input logic [3:0] dst,
		input logic [7:0] imm);
		return {1'b0, fn, dst, imm};   // class == function for 0..7
	endfunction

	function automatic logic [15:0] reg_word(input logic [2:0] fn, input logic [3:0] dst,
		input logic [3:0] src);
		return {`APU_CLS_ALUR, dst, 1'b0, fn, src};
	endfunction

	function automatic logic [15:0] unary_word(input logic [1:0] un, input logic [3:0] dst,
		input logic [3:0] src);
		return {`APU_CLS_UNARY, dst, 2'b00, un, src};
	endfunction

	function automatic logic [15:0] jump_word(input logic [3:0] cond, input logic [7:0] off);
		return {`APU_CLS_JR, cond, off};
	endfunction

	function automatic logic [15:0] out_word(input logic [3:0] port, input logic [3:0] src);
		return {`APU_CLS_OUT, port, 4'h0, src};
	endfunction

	task new_program;
		prog.delete();
		covox_exp.delete();
		border_exp.delete();
	endtask

	task emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	// jump over "ld r11,11" when taken, then output r11
	task pick_on_flag(input logic [3:0] cond, input logic taken);
		emit(jump_word(cond, 8'd3));
		emit(imm_word(`APU_FN_LD, 4'd11, 8'h11));
		emit(jump_word(4'd0, 8'd2));                 // skip the other load
		emit(imm_word(`APU_FN_LD, 4'd11, 8'h22));
		emit(out_word(`APU_PORT_COVOX, 4'd11));
		covox_exp.push_back(taken ? 8'h22 : 8'h11);
	endtask

	// byte pairs, low then high, halt held high
	task load_program;
		logic [7:0] idx;
		@(negedge clk);
		apu_halt = 1'b1;
		for (int i = 0; i < prog.size(); i++)
		begin
			idx = i[7:0];
			@(negedge clk);
			code_wen   = 1'b1;
			code_waddr = {idx, 1'b0};
			code_wdata = prog[i][7:0];
			@(negedge clk);
			code_waddr = {idx, 1'b1};
			code_wdata = prog[i][15:8];
		end
		@(negedge clk);
		code_wen = 1'b0;
		repeat (2) @(negedge clk);  // word 0 back in the fetch register
	endtask

	task compare_queues;
		check_value("covox count", 32'(covox_got.size()), 32'(covox_exp.size()));
		for (int i = 0; i < covox_exp.size(); i++)
			check_value("apu_covox", 32'(covox_got[i]), 32'(covox_exp[i]));
		check_value("border count", 32'(border_got.size()), 32'(border_exp.size()));
		for (int i = 0; i < border_exp.size(); i++)
			check_value("apu_border", 32'(border_got[i]), 32'(border_exp[i]));
	endtask

	// release halt and run up to the done word
	task start_program;
		covox_got.delete();
		border_got.delete();
		apu_halt = 1'b0;
		wait_ready(500);
		compare_queues();
	endtask

	task reset_idle;
		@(negedge clk);
		check_value("apu_rdy", 32'(apu_rdy), 32'd0);
		check_value("apu_covox_we", 32'(apu_covox_we), 32'd0);
		check_value("apu_border_we", 32'(apu_border_we), 32'd0);
		check_value("apu_covox", 32'(apu_covox), 32'd0);
		check_value("apu_border", 32'(apu_border), 32'd0);
	endtask

	task imm_alu_ops;
		logic [7:0] v;
		new_program();
		v = 8'h3c;
		emit(imm_word(`APU_FN_LD, 4'd1, 8'h3c));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		v = v + 8'hd5;                              // wraps
		emit(imm_word(`APU_FN_ADD, 4'd1, 8'hd5));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		v = v - 8'h20;
		emit(imm_word(`APU_FN_SUB, 4'd1, 8'h20));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		v = v & 8'h5a;
		emit(imm_word(`APU_FN_AND, 4'd1, 8'h5a));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		v = v | 8'h03;
		emit(imm_word(`APU_FN_OR, 4'd1, 8'h03));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		v = v ^ 8'hff;
		emit(imm_word(`APU_FN_XOR, 4'd1, 8'hff));
		emit(out_word(`APU_PORT_COVOX, 4'd1));
		covox_exp.push_back(v);
		emit(`APU_INSTR_DONE);
		load_program();
		start_program();
	endtask

	task reg_and_unary_ops;
		logic [7:0] a;
		logic [7:0] b;
		logic [8:0] s9;
		logic [8:0] d9;
		logic [8:0] n9;
		for (int k = 0; k < 4; k++)
		begin
			rnd = $random(seed);
			a   = rnd[7:0];
			b   = rnd[15:8];
			s9  = {1'b0, a} + {1'b0, b};
			d9  = {1'b0, a} - {1'b0, b};           // bit 8 is the borrow
			n9  = 9'd0 - {1'b0, b};
			new_program();
			emit(imm_word(`APU_FN_LD, 4'd2, a));
			emit(imm_word(`APU_FN_LD, 4'd3, b));
			emit(reg_word(`APU_FN_LD, 4'd4, 4'd2));
			emit(reg_word(`APU_FN_ADD, 4'd4, 4'd3));
			emit(out_word(`APU_PORT_COVOX, 4'd4));
			covox_exp.push_back(s9[7:0]);
			pick_on_flag(4'd6, !s9[8]);             // not C after add
			emit(imm_word(`APU_FN_LD, 4'd5, a));
			emit(reg_word(`APU_FN_SUB, 4'd5, 4'd3));
			emit(out_word(`APU_PORT_COVOX, 4'd5));
			covox_exp.push_back(d9[7:0]);
			emit(imm_word(`APU_FN_LD, 4'd6, a));
			emit(reg_word(`APU_FN_XOR, 4'd6, 4'd3));
			emit(out_word(`APU_PORT_COVOX, 4'd6));
			covox_exp.push_back(a ^ b);
			emit(unary_word(`APU_UN_INC, 4'd7, 4'd3));
			emit(out_word(`APU_PORT_COVOX, 4'd7));
			covox_exp.push_back(b + 8'd1);
			emit(unary_word(`APU_UN_DEC, 4'd8, 4'd2));
			emit(out_word(`APU_PORT_COVOX, 4'd8));
			covox_exp.push_back(a - 8'd1);
			emit(unary_word(`APU_UN_CPL, 4'd9, 4'd2));
			emit(out_word(`APU_PORT_COVOX, 4'd9));
			covox_exp.push_back(~a);
			emit(unary_word(`APU_UN_NEG, 4'd10, 4'd3));
			emit(out_word(`APU_PORT_COVOX, 4'd10));
			covox_exp.push_back(n9[7:0]);
			pick_on_flag(4'd2, n9[8]);              // C set unless b is zero
			emit(reg_word(`APU_FN_CMP, 4'd2, 4'd3));
			pick_on_flag(4'd2, d9[8]);
			emit(out_word(`APU_PORT_COVOX, 4'd2)); // cmp must leave r2 alone
			covox_exp.push_back(a);
			emit(`APU_INSTR_DONE);
			load_program();
			start_program();
		end
	endtask

	task jump_loop;
		logic [7:0] n;
		rnd = $random(seed);
		n   = {5'd0, rnd[2:0]} + 8'd3;
		new_program();
		emit(imm_word(`APU_FN_LD, 4'd1, n));
		emit(out_word(`APU_PORT_COVOX, 4'd1));      // loop head
		emit(unary_word(`APU_UN_DEC, 4'd1, 4'd1));
		emit(jump_word(4'd3, 8'hfe));               // back two while not Z
		for (logic [7:0] v = n; v != 8'd0; v--)
			covox_exp.push_back(v);
		emit(imm_word(`APU_FN_LD, 4'd2, 8'h77));
		for (int c = 9; c <= 15; c++)
		begin
			emit(jump_word(c[3:0], 8'd2));           // would skip the out
			emit(out_word(`APU_PORT_COVOX, 4'd2));
			covox_exp.push_back(8'h77);
		end
		emit(`APU_INSTR_DONE);
		load_program();
		start_program();
	endtask

	task border_and_restart;
		logic [7:0] v;
		rnd = $random(seed);
		v   = rnd[7:0];
		new_program();
		emit(imm_word(`APU_FN_LD, 4'd3, v));
		emit(out_word(`APU_PORT_BORDER, 4'd3));
		border_exp.push_back({2'b00, v[5:0]});
		emit(out_word(4'd7, 4'd3));                 // unused port, no strobe
		emit(imm_word(`APU_FN_LD, 4'd4, 8'h5a));
		emit(out_word(`APU_PORT_COVOX, 4'd4));
		covox_exp.push_back(8'h5a);
		emit(imm_word(`APU_FN_XOR, 4'd3, 8'hff));
		emit(out_word(`APU_PORT_BORDER, 4'd3));
		v = ~v;
		border_exp.push_back({2'b00, v[5:0]});
		emit(`APU_INSTR_DONE);
		load_program();
		start_program();
		// halt while parked, then rerun without reloading
		apu_halt = 1'b1;
		@(negedge clk);
		check_value("apu_rdy", 32'(apu_rdy), 32'd0);
		start_program();
	endtask

	initial
	begin
		seed       = 32'ha0b0;
		rst        = 1'b1;
		apu_halt   = 1'b1;
		code_wen   = 1'b0;
		code_waddr = '0;
		code_wdata = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		reset_idle();
		imm_alu_ops();
		reg_and_unary_ops();
		jump_loop();
		border_and_restart();

		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== apu_sva.sv ====
module apu_sva
(
	input logic clk,
	input logic rst,
	input logic apu_halt,
	input logic apu_rdy,
	input logic apu_covox_we,
	input logic apu_border_we
);

	// outputs quiet through reset and the cycle after it
	property quiet_after_rst;
		@(posedge clk) rst |=> (!apu_rdy && !apu_covox_we && !apu_border_we);
	endproperty

	property one_strobe;
		@(posedge clk) !(apu_covox_we && apu_border_we); // one out per cycle
	endproperty

	// halt drops rdy on the next edge
	property halt_drops_rdy;
		@(posedge clk) apu_halt |=> !apu_rdy;
	endproperty

	a_quiet_after_rst: assert property (quiet_after_rst)
		else $error("strobe or apu_rdy high right after reset");

	a_one_strobe: assert property (one_strobe)
		else $error("covox and border strobes high together");

	a_halt_drops_rdy: assert property (halt_drops_rdy)
		else $error("apu_rdy high one cycle after apu_halt");

endmodule

bind apu apu_sva u_sva (
	.clk           (clk),
	.rst           (rst),
	.apu_halt      (apu_halt),
	.apu_rdy       (apu_rdy),
	.apu_covox_we  (apu_covox_we),
	.apu_border_we (apu_border_we)
);

// ==== apu.sv ====
module apu
(
	input  logic                clk,
	input  logic                rst,
	input  logic                apu_halt,
	input  logic                code_wen,
	input  apu_pkg::load_addr_t code_waddr,
	input  apu_pkg::data_t      code_wdata,
	output logic                apu_rdy,
	output apu_pkg::data_t      apu_covox,
	output logic                apu_covox_we,
	output apu_pkg::border_t    apu_border,
	output logic                apu_border_we
);

	apu_pkg::pc_t      rd_addr;     // next fetch address
	apu_pkg::instr_t   instr;
	apu_pkg::reg_idx_t reg_a;
	apu_pkg::reg_idx_t reg_b;
	apu_pkg::data_t    imm;
	apu_pkg::data_t    offset;
	apu_pkg::fn_t      fn;
	apu_pkg::un_t      un_fn;
	apu_pkg::cond_t    cond;
	apu_pkg::port_t    port;
	apu_pkg::data_t    rd_a;
	apu_pkg::data_t    rd_b;
	apu_pkg::data_t    result;
	logic              use_imm, unary, wr_en, flag_en, jump_en, out_en;
	logic              flag_z, flag_c, flag_n;
	logic              z_next, c_next, n_next;

	apu_code_ram u_code_ram (
		.clk, .code_wen, .code_waddr, .code_wdata, .rd_addr, .instr
	);

	apu_fetch u_fetch (
		.clk, .rst, .apu_halt, .instr, .jump_en, .cond, .offset,
		.flag_z, .flag_c, .flag_n, .rd_addr, .apu_rdy
	);

	apu_decode u_decode (
		.instr, .apu_halt, .rst, .reg_a, .reg_b, .imm, .use_imm, .unary,
		.wr_en, .flag_en, .jump_en, .out_en, .fn, .un_fn, .cond, .offset, .port
	);

	// dst reg is the first operand
	apu_alu u_alu (
		.op_a(rd_a), .op_b(rd_b), .imm, .use_imm, .unary, .fn, .un_fn,
		.result, .z_next, .c_next, .n_next
	);

	apu_regs u_regs (
		.clk, .rst, .reg_a, .reg_b, .wr_en, .flag_en, .wr_data(result),
		.z_next, .c_next, .n_next, .rd_a, .rd_b, .flag_z, .flag_c, .flag_n
	);

	// out takes its value from the src reg
	apu_port_out u_port_out (
		.clk, .rst, .out_en, .port, .out_data(rd_b),
		.apu_covox, .apu_covox_we, .apu_border, .apu_border_we
	);

endmodule

// ==== apu_port_out.sv ====
`include "apu_config.svh"

module apu_port_out
(
	input  logic             clk,
	input  logic             rst,
	input  logic             out_en,
	input  apu_pkg::port_t   port,
	input  apu_pkg::data_t   out_data,
	output apu_pkg::data_t   apu_covox,
	output logic             apu_covox_we,
	output apu_pkg::border_t apu_border,
	output logic             apu_border_we
);

	logic hit_covox;
	logic hit_border;

	assign hit_covox  = out_en && (port == `APU_PORT_COVOX);
	assign hit_border = out_en && (port == `APU_PORT_BORDER);   // other ports dropped

	// one cycle behind execute
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			apu_covox     <= '0;
			apu_border    <= '0;
			apu_covox_we  <= 1'b0;
			apu_border_we <= 1'b0;
		end
		else
		begin
			apu_covox_we  <= hit_covox;   // single pulse per out
			apu_border_we <= hit_border;
			if (hit_covox)
				apu_covox <= out_data;
			if (hit_border)
				apu_border <= out_data[`APU_BORDER_W-1:0]; // low bits only
		end
	end

endmodule

// ==== apu_regs.sv ====
`include "apu_config.svh"

module apu_regs
(
	input  logic              clk,
	input  logic              rst,
	input  apu_pkg::reg_idx_t reg_a,
	input  apu_pkg::reg_idx_t reg_b,
	input  logic              wr_en,
	input  logic              flag_en,
	input  apu_pkg::data_t    wr_data,
	input  logic              z_next,
	input  logic              c_next,
	input  logic              n_next,
	output apu_pkg::data_t    rd_a,
	output apu_pkg::data_t    rd_b,
	output logic              flag_z,
	output logic              flag_c,
	output logic              flag_n
);

	localparam int NREGS = 1 << `APU_REG_AW;

	apu_pkg::data_t gpr [NREGS];  // general registers

	// async reads, dst and src
	assign rd_a = gpr[reg_a];
	assign rd_b = gpr[reg_b];

	// single write port, always to dst
	always_ff @(posedge clk)
	begin
		if (wr_en)
			gpr[reg_a] <= wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			{flag_z, flag_c, flag_n} <= 3'b000;
		else if (flag_en)
			{flag_z, flag_c, flag_n} <= {z_next, c_next, n_next}; // every alu/unary op
	end

endmodule

// ==== apu_alu.sv ====
`include "apu_config.svh"

module apu_alu
(
	input  apu_pkg::data_t op_a,
	input  apu_pkg::data_t op_b,
	input  apu_pkg::data_t imm,
	input  logic           use_imm,
	input  logic           unary,
	input  apu_pkg::fn_t   fn,
	input  apu_pkg::un_t   un_fn,
	output apu_pkg::data_t result,
	output logic           z_next,
	output logic           c_next,
	output logic           n_next
);

	apu_pkg::data_t        op2;   // second operand
	logic [`APU_DATA_W:0]  bin9;  // 9 bit results, bit 8 is carry/borrow
	logic [`APU_DATA_W:0]  un9;
	logic [`APU_DATA_W:0]  res9;

	assign op2 = use_imm ? imm : op_b;

	// binary, logic ops leave bit 8 clear
	always_comb
	begin
		case (fn)
			`APU_FN_LD:  bin9 = {1'b0, op2};
			`APU_FN_AND: bin9 = {1'b0, op_a & op2};
			`APU_FN_OR:  bin9 = {1'b0, op_a | op2};
			`APU_FN_XOR: bin9 = {1'b0, op_a ^ op2};
			`APU_FN_ADD: bin9 = {1'b0, op_a} + {1'b0, op2};
			`APU_FN_SUB: bin9 = {1'b0, op_a} - {1'b0, op2};
			`APU_FN_CMP: bin9 = {1'b0, op_a} - {1'b0, op2}; // flags only
			default:     bin9 = {1'b0, op_a & op2};         // tst
		endcase
	end

	// unary works on the source reg
	always_comb
	begin
		case (un_fn)
			`APU_UN_INC: un9 = {1'b0, op_b} + 9'd1;
			`APU_UN_DEC: un9 = {1'b0, op_b} - 9'd1;
			`APU_UN_CPL: un9 = {1'b0, ~op_b};
			default:     un9 = 9'd0 - {1'b0, op_b};  // neg
		endcase
	end

	assign res9   = unary ? un9 : bin9;
	assign result = res9[`APU_DATA_W-1:0];

	// flags
	assign z_next = (result == '0);
	assign c_next = res9[`APU_DATA_W];
	assign n_next = result[`APU_DATA_W-1];

endmodule

// ==== apu_decode.sv ====
`include "apu_config.svh"

module apu_decode
(
	input  apu_pkg::instr_t   instr,
	input  logic              apu_halt,
	input  logic              rst,
	output apu_pkg::reg_idx_t reg_a,
	output apu_pkg::reg_idx_t reg_b,
	output apu_pkg::data_t    imm,
	output logic              use_imm,
	output logic              unary,
	output logic              wr_en,
	output logic              flag_en,
	output logic              jump_en,
	output logic              out_en,
	output apu_pkg::fn_t      fn,
	output apu_pkg::un_t      un_fn,
	output apu_pkg::cond_t    cond,
	output apu_pkg::data_t    offset,
	output apu_pkg::port_t    port
);

	logic [3:0] cls;        // instruction class
	logic       run;        // low while halted or in reset
	logic       alu_imm;
	logic       alu_reg;
	logic       no_wb;      // cmp, tst

	assign cls = instr[15:12];
	assign run = !(rst || apu_halt);

	// plain field slices
	assign reg_a  = instr[11:8];   // dst
	assign reg_b  = instr[3:0];    // src
	assign imm    = instr[7:0];
	assign offset = instr[7:0];    // signed rel
	assign cond   = instr[11:8];
	assign port   = instr[11:8];
	assign un_fn  = instr[5:4];

	assign alu_imm = (cls <= `APU_CLS_TST);
	assign alu_reg = (cls == `APU_CLS_ALUR);
	assign unary   = (cls == `APU_CLS_UNARY);
	assign use_imm = alu_imm;

	// imm classes carry the function in the class itself
	assign fn = alu_imm ? instr[14:12] : instr[6:4];

	assign no_wb = (fn == `APU_FN_CMP) || (fn == `APU_FN_TST);

	// enables, all dead while halted
	assign wr_en   = run && (unary || ((alu_imm || alu_reg) && !no_wb));
	assign flag_en = run && (alu_imm || alu_reg || unary);
	assign jump_en = run && (cls == `APU_CLS_JR);
	assign out_en  = run && (cls == `APU_CLS_OUT);

endmodule

// ==== apu_fetch.sv ====
`include "apu_config.svh"

module apu_fetch
(
	input  logic             clk,
	input  logic             rst,
	input  logic             apu_halt,
	input  apu_pkg::instr_t  instr,
	input  logic             jump_en,
	input  apu_pkg::cond_t   cond,
	input  apu_pkg::data_t   offset,
	input  logic             flag_z,
	input  logic             flag_c,
	input  logic             flag_n,
	output apu_pkg::pc_t     rd_addr,
	output logic             apu_rdy
);

	apu_pkg::pc_t pc;       // address of the word now in instr
	apu_pkg::pc_t pc_inc;
	apu_pkg::pc_t pc_rel;
	logic         taken;
	logic         is_done;

	assign is_done = (instr == `APU_INSTR_DONE);
	assign pc_inc  = pc + apu_pkg::pc_t'(1);
	assign pc_rel  = pc + offset;   // 8 bit add == sign-extend mod 256

	// condition table
	always_comb
	begin
		case (cond)
			4'd0:    taken = 1'b1;               // always
			4'd1:    taken = flag_z;             // equal
			4'd2:    taken = flag_c;             // less
			4'd3:    taken = !flag_z;            // not equal
			4'd4:    taken = !flag_c && !flag_z; // greater
			4'd5:    taken = flag_c || flag_z;   // less or equal
			4'd6:    taken = !flag_c;            // greater or equal
			4'd7:    taken = flag_n;
			4'd8:    taken = !flag_n;
			default: taken = 1'b0;               // 9..15 never
		endcase
	end

	// next address doubles as the ram read address
	always_comb
	begin
		if (rst || apu_halt)
			rd_addr = '0;      // restart point
		else if (is_done)
			rd_addr = pc;      // parked
		else if (jump_en && taken)
			rd_addr = pc_rel;
		else
			rd_addr = pc_inc;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc      <= '0;
			apu_rdy <= 1'b0;
		end
		else
		begin
			pc      <= rd_addr;
			apu_rdy <= is_done && !apu_halt; // drops the edge after halt rises
		end
	end

endmodule

// ==== apu_code_ram.sv ====
`include "apu_config.svh"

module apu_code_ram
(
	input  logic                clk,
	input  logic                code_wen,
	input  apu_pkg::load_addr_t code_waddr,
	input  apu_pkg::data_t      code_wdata,
	input  apu_pkg::pc_t        rd_addr,
	output apu_pkg::instr_t     instr
);

	localparam int DEPTH = 1 << `APU_CODE_AW;

	apu_pkg::instr_t mem [DEPTH];
	apu_pkg::data_t  lo_byte;   // even byte waits here for its pair

	logic even_wr;
	logic odd_wr;

	assign even_wr = code_wen && !code_waddr[0];
	assign odd_wr  = code_wen && code_waddr[0];

	// loader side
	always_ff @(posedge clk)
	begin
		if (even_wr)
			lo_byte <= code_wdata;
		if (odd_wr)
			mem[code_waddr[`APU_LOAD_AW-1:1]] <= {code_wdata, lo_byte}; // high byte completes word
	end

	// fetch side, one clock latency
	always_ff @(posedge clk)
	begin
		instr <= mem[rd_addr];
	end

endmodule

// ==== apu_pkg.sv ====
`include "apu_config.svh"

package apu_pkg;

	// code word
	typedef logic [`APU_INSTR_W-1:0] instr_t;

	// general register value
	typedef logic [`APU_DATA_W-1:0] data_t;

	typedef logic [`APU_REG_AW-1:0] reg_idx_t;   // register number

	// code word address, wraps at 256
	typedef logic [`APU_CODE_AW-1:0] pc_t;

	typedef logic [`APU_LOAD_AW-1:0] load_addr_t; // byte address for loading

	typedef logic [2:0] fn_t;       // binary alu function
	typedef logic [1:0] un_t;       // unary function
	typedef logic [3:0] cond_t;     // jump condition
	typedef logic [3:0] port_t;     // output port number

	// border colour, low bits of the source reg
	typedef logic [`APU_BORDER_W-1:0] border_t;

endpackage

// ==== apu_config.svh ====
`ifndef APU_CONFIG_SVH
`define APU_CONFIG_SVH

// widths
`define APU_INSTR_W       16
`define APU_DATA_W        8
`define APU_CODE_AW       8     // 256 code words
`define APU_LOAD_AW       9     // byte address into code memory
`define APU_REG_AW        4     // 16 general registers
`define APU_BORDER_W      6

// instruction classes, bits 15:12
`define APU_CLS_LD        4'd0  // classes 0..7 are the immediate alu ops
`define APU_CLS_AND       4'd1
`define APU_CLS_OR        4'd2
`define APU_CLS_XOR       4'd3
`define APU_CLS_ADD       4'd4
`define APU_CLS_SUB       4'd5
`define APU_CLS_CMP       4'd6
`define APU_CLS_TST       4'd7
`define APU_CLS_ALUR      4'd8  // reg, reg
`define APU_CLS_UNARY     4'd9
`define APU_CLS_JR        4'd10
`define APU_CLS_OUT       4'd11

// binary alu functions
`define APU_FN_LD         3'd0
`define APU_FN_AND        3'd1
`define APU_FN_OR         3'd2
`define APU_FN_XOR        3'd3
`define APU_FN_ADD        3'd4
`define APU_FN_SUB        3'd5
`define APU_FN_CMP        3'd6
`define APU_FN_TST        3'd7

// unary functions
`define APU_UN_INC        2'd0
`define APU_UN_DEC        2'd1
`define APU_UN_CPL        2'd2
`define APU_UN_NEG        2'd3

// output ports
`define APU_PORT_COVOX    4'd5
`define APU_PORT_BORDER   4'd6

`define APU_INSTR_DONE    16'hffff  // park and raise apu_rdy

`endif
